/* src/mini_core_accel_pkg.sv */
`default_nettype none

package mini_core_accel_pkg;

    // Operand width in bits
    localparam int NUM_WIDTH = 8;

    // Operand pairs held between request and multiplier
    localparam int FIFO_DEPTH = 4;

    typedef logic signed [NUM_WIDTH-1:0] t_operand;

    typedef logic signed [2*NUM_WIDTH-1:0] t_product;

    // FIFO payload, one multiply request
    typedef struct packed {
        t_operand multiplicand;
        t_operand multiplier;
    } t_operand_pair;

endpackage

`default_nettype wire

/* src/fifo_if.sv */
`timescale 1ns/1ps
`default_nettype none

interface fifo_if;
    import mini_core_accel_pkg::*;

    logic          push;
    t_operand_pair push_data;
    logic          full;
    logic          pop;
    t_operand_pair pop_data; // Oldest entry, valid while not empty
    logic          empty;

    modport producer (output push, output push_data, input full);

    modport consumer (output pop, input pop_data, input empty);

    modport buffer (
        input  push,
        input  push_data,
        output full,
        input  pop,
        output pop_data,
        output empty
    );

endinterface

`default_nettype wire

/* src/mul_request.sv */
`timescale 1ns/1ps
`default_nettype none

module mul_request (
    input  logic                          clock,
    input  logic                          arst_n,
    input  logic                          req,
    input  mini_core_accel_pkg::t_operand multiplicand,
    input  mini_core_accel_pkg::t_operand multiplier,
    output logic                          overflow,
    fifo_if.producer                      q
);

    logic drop;

    // Request is taken in the same cycle when there is room
    assign q.push = req && !q.full;

    assign q.push_data.multiplicand = multiplicand;
    assign q.push_data.multiplier   = multiplier;

    // Request meets a full FIFO and is lost
    assign drop = req && q.full;

    // Sticky until reset
    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            overflow <= 1'b0;
        end else if (drop) begin
            overflow <= 1'b1;
        end
    end

endmodule

`default_nettype wire

/* src/operand_fifo.sv */
`timescale 1ns/1ps
`default_nettype none

module operand_fifo #(
    parameter int DEPTH = mini_core_accel_pkg::FIFO_DEPTH
) (
    input  logic  clock,
    input  logic  arst_n,
    fifo_if.buffer q
);
    import mini_core_accel_pkg::*;

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    t_operand_pair mem [DEPTH];

    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;

    assign q.empty    = (count == '0);
    assign q.full     = (count == CNT_W'(DEPTH));
    assign q.pop_data = mem[rd_ptr];

    always_ff @(posedge clock) begin
        if (q.push) begin
            mem[wr_ptr] <= q.push_data;
        end
    end

    // Pointers wrap at DEPTH, which need not be a power of two
    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (q.push) begin
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (q.pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
        end
    end

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            count <= '0;
        end else begin
            case ({q.push, q.pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: ; // Both or neither, level unchanged
            endcase
        end
    end

endmodule

`default_nettype wire

/* src/booth_multiplier.sv */
`timescale 1ns/1ps
`default_nettype none

module booth_multiplier (
    input  logic                          clock,
    input  logic                          arst_n,
    fifo_if.consumer                      q,
    output mini_core_accel_pkg::t_product result,
    output logic                          done
);
    import mini_core_accel_pkg::*;

    // Partial product with extra sign bit, multiplier bits, guard bit
    localparam int ACC_W = 2*NUM_WIDTH + 2;
    localparam int CNT_W = (NUM_WIDTH > 2) ? $clog2(NUM_WIDTH) : 1;

    typedef enum logic {IDLE, COMPUTE} t_state;

    t_state               state;
    logic [ACC_W-1:0]     acc;
    logic [ACC_W-1:0]     acc_step;
    logic [NUM_WIDTH:0]   mcand;   // Sign extended multiplicand
    logic [NUM_WIDTH:0]   partial;
    logic [CNT_W-1:0]     itr_cnt;
    logic                 last_step;

    assign q.pop     = (state == IDLE) && !q.empty;
    assign last_step = (state == COMPUTE) && (itr_cnt == '0);

    // One Booth step on the low two bits, then arithmetic shift right
    always_comb begin
        partial = acc[ACC_W-1:NUM_WIDTH+1];
        case (acc[1:0])
            2'b01:   partial = partial + mcand;
            2'b10:   partial = partial - mcand;
            default: ;
        endcase
        acc_step = {partial[NUM_WIDTH], partial, acc[NUM_WIDTH:1]};
    end

    always_ff @(posedge clock) begin
        if (q.pop) begin
            acc   <= {{(NUM_WIDTH+1){1'b0}}, q.pop_data.multiplier, 1'b0};
            mcand <= {q.pop_data.multiplicand[NUM_WIDTH-1], q.pop_data.multiplicand};
        end else if (state == COMPUTE) begin
            acc <= acc_step;
        end
    end

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            state   <= IDLE;
            itr_cnt <= '0;
        end else begin
            case (state)
                IDLE: begin
                    if (q.pop) begin
                        state   <= COMPUTE;
                        itr_cnt <= CNT_W'(NUM_WIDTH - 1);
                    end
                end
                COMPUTE: begin
                    if (last_step) begin
                        state <= IDLE;
                    end else begin
                        itr_cnt <= itr_cnt - 1'b1;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    // Product held until the next one, marked by a single cycle pulse
    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            result <= '0;
            done   <= 1'b0;
        end else begin
            done <= last_step;
            if (last_step) begin
                result <= acc_step[2*NUM_WIDTH:1];
            end
        end
    end

endmodule

`default_nettype wire

/* src/mul_accel_top.sv */
`timescale 1ns/1ps
`default_nettype none

module mul_accel_top (
    input  logic                          clock,
    input  logic                          arst_n,
    input  logic                          req,
    input  mini_core_accel_pkg::t_operand multiplicand,
    input  mini_core_accel_pkg::t_operand multiplier,
    output mini_core_accel_pkg::t_product result,
    output logic                          done,
    output logic                          overflow
);
    import mini_core_accel_pkg::*;

    fifo_if operand_q ();

    // Request strobe into FIFO pushes
    mul_request u_request (
        .clock        (clock),
        .arst_n       (arst_n),
        .req          (req),
        .multiplicand (multiplicand),
        .multiplier   (multiplier),
        .overflow     (overflow),
        .q            (operand_q.producer)
    );

    operand_fifo #(
        .DEPTH (FIFO_DEPTH)
    ) u_fifo (
        .clock  (clock),
        .arst_n (arst_n),
        .q      (operand_q.buffer)
    );

    // Pops one pair at a time
    booth_multiplier u_booth (
        .clock  (clock),
        .arst_n (arst_n),
        .q      (operand_q.consumer),
        .result (result),
        .done   (done)
    );

endmodule

`default_nettype wire

/* testbench/tb_clock.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_clock (
    output logic clock,
    output logic arst_n
);

    localparam int HALF_PERIOD  = 5; // 10 ns period
    localparam int RESET_CYCLES = 16;

    initial begin
        clock = 1'b0;
        forever #HALF_PERIOD clock = ~clock;
    end

    initial begin
        arst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clock);
        arst_n <= 1'b1;
    end

endmodule

`default_nettype wire

/* testbench/mul_accel_assert.sv */
`timescale 1ns/1ps
`default_nettype none

module mul_accel_assert (
    input logic clock,
    input logic arst_n,
    input logic push,
    input logic full,
    input logic pop,
    input logic empty,
    input logic done
);
    import mini_core_accel_pkg::*;

    property no_push_when_full;
        @(posedge clock) disable iff (!arst_n) push |-> !full;
    endproperty

    property no_pop_when_empty;
        @(posedge clock) disable iff (!arst_n) pop |-> !empty;
    endproperty

    property done_single_cycle;
        @(posedge clock) disable iff (!arst_n) done |=> !done;
    endproperty

    // Next product needs a pop plus NUM_WIDTH steps
    property done_spacing;
        @(posedge clock) disable iff (!arst_n) done |=> (!done) [*NUM_WIDTH];
    endproperty

    a_no_push_full:  assert property (no_push_when_full) else $error("push while FIFO full");
    a_no_pop_empty:  assert property (no_pop_when_empty) else $error("pop while FIFO empty");
    a_done_single:   assert property (done_single_cycle) else $error("done longer than one cycle");
    a_done_spacing:  assert property (done_spacing) else $error("done pulses too close together");

endmodule

bind mul_accel_top mul_accel_assert u_assert (
    .clock  (clock),
    .arst_n (arst_n),
    .push   (operand_q.push),
    .full   (operand_q.full),
    .pop    (operand_q.pop),
    .empty  (operand_q.empty),
    .done   (done)
);

`default_nettype wire

/* testbench/tb_mul_accel.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_mul_accel;
    import mini_core_accel_pkg::*;

    localparam int SEED_VALUE      = 32'h7d71;
    localparam int NUM_RANDOM      = 20;
    localparam int BURST_LEN       = 8;
    localparam int MARGIN_CYCLES   = 200;
    localparam int TOTAL_VECTORS   = 5 + 2 + NUM_RANDOM + BURST_LEN;
    localparam int WATCHDOG_CYCLES = 16 + TOTAL_VECTORS * (NUM_WIDTH + 4) + MARGIN_CYCLES;
    localparam int DONE_LIMIT      = 4 * (NUM_WIDTH + 2);

    logic     clock;
    logic     arst_n;
    logic     req;
    t_operand multiplicand;
    t_operand multiplier;
    t_product result;
    logic     done;
    logic     overflow;

    int       errors;
    int       checks;
    integer   seed;
    t_product expected_q[$]; // Products in request order

    tb_clock u_clock (.clock(clock), .arst_n(arst_n));

    mul_accel_top uut (
        .clock        (clock),
        .arst_n       (arst_n),
        .req          (req),
        .multiplicand (multiplicand),
        .multiplier   (multiplier),
        .result       (result),
        .done         (done),
        .overflow     (overflow)
    );

    function automatic t_product ref_product(input t_operand a, input t_operand b);
        return t_product'(a) * t_product'(b);
    endfunction

    task automatic check_product(input string name, input t_product expected,
                                 input t_product actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("FAILED %s: expected %0d, actual %0d", name, expected, actual);
        end
    endtask

    task automatic check_flag(input string name, input logic expected, input logic actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("FAILED %s: expected %b, actual %b", name, expected, actual);
        end
    endtask

    task automatic check_latency(input string name, input int expected, input int actual);
        checks++;
        if (actual != expected) begin
            errors++;
            $display("FAILED %s: expected %0d, actual %0d", name, expected, actual);
        end
    endtask

    // Single cycle strobe, returns just after the edge that takes it
    task automatic drive_request(input t_operand a, input t_operand b);
        @(posedge clock);
        req          <= 1'b1;
        multiplicand <= a;
        multiplier   <= b;
        @(posedge clock);
        req <= 1'b0;
    endtask

    task automatic wait_done(input string name, output int cycles, output bit seen);
        seen   = 1'b0;
        cycles = 0;
        while (!seen && cycles < DONE_LIMIT) begin
            @(negedge clock);
            cycles++;
            seen = (done === 1'b1);
        end
        if (!seen) begin
            errors++;
            $display("%s: no done pulse within %0d cycles", name, DONE_LIMIT);
        end
    endtask

    task automatic collect_products(input string name, input int count);
        int cycles;
        bit seen;
        int n;
        n    = 0;
        seen = 1'b1;
        while (seen && n < count) begin
            wait_done(name, cycles, seen);
            if (seen) begin
                check_product(name, expected_q.pop_front(), result);
            end
            n++;
        end
        expected_q.delete();
    endtask

    task automatic test_reset();
        check_product("reset_result", '0, result);
        check_flag("reset_done", 1'b0, done);
        check_flag("reset_overflow", 1'b0, overflow);
    endtask

    task automatic test_single(input string name, input t_operand a, input t_operand b);
        int cycles;
        bit seen;
        drive_request(a, b);
        wait_done(name, cycles, seen);
        if (seen) begin
            check_latency({name, "_latency"}, NUM_WIDTH + 2, cycles);
            check_product(name, ref_product(a, b), result);
        end
    endtask

    task automatic test_corners();
        test_single("min_x_min", -8'sd128, -8'sd128);
        test_single("min_x_max", -8'sd128, 8'sd127);
        test_single("max_x_max", 8'sd127, 8'sd127);
        test_single("zero_x_neg1", 8'sd0, -8'sd1);
        test_single("neg1_x_neg1", -8'sd1, -8'sd1);
    endtask

    // Same pair on two consecutive edges
    task automatic test_identical();
        @(posedge clock);
        req          <= 1'b1;
        multiplicand <= -8'sd37;
        multiplier   <= 8'sd91;
        @(posedge clock);
        @(posedge clock);
        req <= 1'b0;
        expected_q.push_back(ref_product(-8'sd37, 8'sd91));
        expected_q.push_back(ref_product(-8'sd37, 8'sd91));
        collect_products("identical", 2);
    endtask

    task automatic test_random();
        t_operand a;
        t_operand b;
        fork
            begin
                for (int i = 0; i < NUM_RANDOM; i++) begin
                    a = t_operand'($random(seed));
                    b = t_operand'($random(seed));
                    expected_q.push_back(ref_product(a, b));
                    drive_request(a, b);
                    repeat (NUM_WIDTH) @(posedge clock);
                end
            end
            collect_products("random", NUM_RANDOM);
        join
        check_flag("random_overflow", 1'b0, overflow);
    endtask

    task automatic test_burst();
        t_operand a;
        t_operand b;
        bit       extra;
        for (int i = 0; i < BURST_LEN; i++) begin
            a = t_operand'(13 * i - 50);
            b = t_operand'(100 - 29 * i);
            if (i < FIFO_DEPTH + 1) begin
                expected_q.push_back(ref_product(a, b)); // Only these fit
            end
            @(posedge clock);
            req          <= 1'b1;
            multiplicand <= a;
            multiplier   <= b;
        end
        @(posedge clock);
        req <= 1'b0;
        @(negedge clock);
        check_flag("burst_overflow_set", 1'b1, overflow);
        collect_products("burst", FIFO_DEPTH + 1);
        extra = 1'b0;
        repeat (3 * (NUM_WIDTH + 1)) begin
            @(negedge clock);
            if (done === 1'b1) begin
                extra = 1'b1;
            end
        end
        if (extra) begin
            errors++;
            $display("burst: done pulse seen after the last accepted request");
        end
        check_flag("burst_overflow_held", 1'b1, overflow);
    endtask

    initial begin
        errors       = 0;
        checks       = 0;
        seed         = SEED_VALUE;
        req          = 1'b0;
        multiplicand = '0;
        multiplier   = '0;
        wait (arst_n === 1'b1);
        @(negedge clock);
        test_reset();
        test_corners();
        test_identical();
        test_random();
        test_burst();
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clock);
        $display("Watchdog: run did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("Something failed");
        $finish;
    end

endmodule

`default_nettype wire

/* vlog.f */
src/mini_core_accel_pkg.sv
src/fifo_if.sv
src/mul_request.sv
src/operand_fifo.sv
src/booth_multiplier.sv
src/mul_accel_top.sv
testbench/tb_clock.sv
testbench/mul_accel_assert.sv
testbench/tb_mul_accel.sv

/* Bender.yml */
package:
  name: mini_core_mul_accel

sources:
  - src/mini_core_accel_pkg.sv
  - src/fifo_if.sv
  - src/mul_request.sv
  - src/operand_fifo.sv
  - src/booth_multiplier.sv
  - src/mul_accel_top.sv
  - target: test
    files:
      - testbench/tb_clock.sv
      - testbench/mul_accel_assert.sv
      - testbench/tb_mul_accel.sv
